// File: nvme_configurator.f
+incdir+verilog
verilog/nvme_cfg_pkg.sv
verilog/cfg_sequencer.sv
verilog/rq_encoder.sv
verilog/rc_decoder.sv
verilog/nvme_configurator.sv
tb/tb_nvme_configurator.sv

// File: tb/tb_nvme_configurator.sv
// Testbench of the NVMe configurator
// Endpoint responder with LFSR delays, beat reference model, request monitor
`default_nettype none

`include "nvme_cfg_defs.svh"

module tb_nvme_configurator;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RUN_CYCLES     = 2000;
  localparam int NUM_RUNS       = 2;
  localparam int TIMEOUT_CYCLES = RUN_CYCLES * NUM_RUNS;

  logic                   user_clk;
  logic                   rst_n;
  logic                   link_up;
  logic                   start_config;
  nvme_cfg_pkg::rc_beat_t rc;
  nvme_cfg_pkg::rq_beat_t rq;
  logic                   cfg_done;

  nvme_cfg_pkg::step_t    exp_step;          // Step the next request must carry
  logic                   beat_phase;        // Payload beat expected next
  event                   req_done;          // Closing beat of a request seen
  logic [15:0]            lfsr = 16'd14;
  logic                   model_rdy;         // Endpoint CSTS.RDY
  logic                   rdy_target;        // Value last written to CC.EN
  int                     poll_lag;          // Polls that still see the old RDY
  int                     lag_left;
  int                     csts_reads;        // CSTS read beats in the current wait step
  int                     cycle_cnt = 0;

  nvme_configurator nvme_configurator_i (
    .user_clk     (user_clk),
    .rst_n        (rst_n),
    .link_up      (link_up),
    .start_config (start_config),
    .rc           (rc),
    .rq           (rq),
    .cfg_done     (cfg_done)
  );

  initial begin
    user_clk = 1'b0;
    forever #5 user_clk = ~user_clk;
  end

  // ----------------------------------------------------------
  // Failure handling and compares
  // ----------------------------------------------------------
  task automatic stop_sim(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_beat(input nvme_cfg_pkg::rq_beat_t got,
                            input nvme_cfg_pkg::rq_beat_t exp, input string what);
    if (got !== exp)
      stop_sim($sformatf("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_done(input logic got, input logic exp, input string what);
    if (got !== exp)
      stop_sim($sformatf("** Error at %0t ns: %s is %b expected %b", $time, what, got, exp));
  endtask

  task automatic check_idle(input nvme_cfg_pkg::rq_beat_t got, input string what);
    if (got.tvalid !== 1'b0)
      stop_sim($sformatf("** Error at %0t ns: unexpected beat on %s", $time, what));
  endtask

  // ----------------------------------------------------------
  // Reference model of the request beats
  // ----------------------------------------------------------
  function automatic nvme_cfg_pkg::rq_beat_t expected_beat(input nvme_cfg_pkg::step_t step,
                                                           input logic phase);
    nvme_cfg_pkg::rq_beat_t  beat;
    nvme_cfg_pkg::req_type_t kind;
    nvme_cfg_pkg::addr_t     addr;
    nvme_cfg_pkg::dw_t       pay;
    logic                    two_dw;
    beat   = '0;
    kind   = nvme_cfg_pkg::mem_wr;
    addr   = {`NVME_BAR0_HI, `NVME_BAR0_LO};     // BAR0 relative by default
    pay    = '0;
    two_dw = (step == nvme_cfg_pkg::asq) || (step == nvme_cfg_pkg::acq);
    case (step)
      nvme_cfg_pkg::cmd_reg: begin
        kind       = nvme_cfg_pkg::cfg_wr0;
        addr       = '0;
        addr[11:2] = `NVME_CMD_REG;
        pay        = `NVME_CMD_VAL;
      end
      nvme_cfg_pkg::bar_lo: begin
        kind       = nvme_cfg_pkg::cfg_wr0;
        addr       = '0;
        addr[11:2] = `NVME_BAR0_REG;
        pay        = `NVME_BAR0_LO;
      end
      nvme_cfg_pkg::bar_hi: begin
        kind       = nvme_cfg_pkg::cfg_wr0;
        addr       = '0;
        addr[11:2] = `NVME_BAR1_REG;
        pay        = `NVME_BAR0_HI;
      end
      nvme_cfg_pkg::cc_disable: addr = addr + `NVME_CC_OFS;
      nvme_cfg_pkg::csts_wait_low, nvme_cfg_pkg::csts_wait_high: begin
        kind = nvme_cfg_pkg::mem_rd;
        addr = addr + `NVME_CSTS_OFS;
      end
      nvme_cfg_pkg::aqa: begin
        addr = addr + `NVME_AQA_OFS;
        pay  = `NVME_AQA_VAL;
      end
      nvme_cfg_pkg::asq: begin
        addr = addr + `NVME_ASQ_OFS;
        pay  = `NVME_ASQ_BASE;
      end
      nvme_cfg_pkg::acq: begin
        addr = addr + `NVME_ACQ_OFS;
        pay  = `NVME_ACQ_BASE;
      end
      default: begin
        addr = addr + `NVME_CC_OFS;                // CC.EN set
        pay  = 32'h0000_0001;
      end
    endcase
    beat.tvalid = 1'b1;
    if (!phase) begin
      beat.tdata[63:0]    = addr;
      beat.tdata[74:64]   = two_dw ? 11'd2 : 11'd1;
      beat.tdata[78:75]   = kind;
      beat.tdata[95:80]   = `NVME_REQ_ID;
      beat.tdata[119:104] = `NVME_CPL_ID;
      beat.tdata[120]     = 1'b1;                  // Requester ID enable
      beat.tkeep          = 4'b1111;
      beat.tuser[3:0]     = 4'b1111;               // First BE
      beat.tuser[7:4]     = two_dw ? 4'b1111 : 4'b0000;
      beat.tlast          = (kind == nvme_cfg_pkg::mem_rd);
    end else begin
      beat.tdata[31:0] = pay;
      beat.tkeep       = two_dw ? 4'b0011 : 4'b0001;
      beat.tlast       = 1'b1;
    end
    return beat;
  endfunction

  function automatic logic is_posted(input nvme_cfg_pkg::step_t step);
    return step inside {nvme_cfg_pkg::cc_disable, nvme_cfg_pkg::aqa, nvme_cfg_pkg::asq,
                        nvme_cfg_pkg::acq, nvme_cfg_pkg::cc_enable};
  endfunction

  // Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] galois_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int count, output int value);
    value = 0;
    repeat (count) begin
      lfsr  = galois_next(lfsr);
      value = (value << 1) | lfsr[0];
    end
  endtask

  // ----------------------------------------------------------
  // Request monitor
  // ----------------------------------------------------------
  always @(negedge user_clk) begin
    if (!rst_n || !link_up) begin
      beat_phase = 1'b0;
    end else if (rq.tvalid) begin
      check_beat(rq, expected_beat(exp_step, beat_phase), "request beat");
      if (exp_step inside {nvme_cfg_pkg::csts_wait_low, nvme_cfg_pkg::csts_wait_high})
        csts_reads = csts_reads + 1;
      beat_phase = !rq.tlast;
      if (rq.tlast)
        ->req_done;
    end
  end

  always @(posedge user_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES)
      stop_sim($sformatf("Timeout: bring-up still running after %0d cycles", TIMEOUT_CYCLES));
  end

  // ----------------------------------------------------------
  // Endpoint responder
  // ----------------------------------------------------------
  task automatic apply_reset();
    @(posedge user_clk);
    rst_n   <= 1'b0;
    link_up <= 1'b0;
    repeat (8) @(posedge user_clk);
    rst_n   <= 1'b1;
  endtask

  task automatic wait_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge user_clk);
      check_idle(rq, "request stream while a completion is pending");
    end
  endtask

  task automatic send_cpl(input logic ok, input logic rdy);
    nvme_cfg_pkg::rc_beat_t beat;
    beat                         = '0;
    beat.tdata[42:32]            = 11'd1;          // One dword
    beat.tdata[`NVME_CPL_OK_BIT] = ok;
    beat.tdata[`NVME_RDY_BIT]    = rdy;
    beat.tlast                   = 1'b1;
    beat.tvalid                  = 1'b1;
    @(posedge user_clk);
    rc <= beat;
    @(posedge user_clk);
    rc <= '0;
  endtask

  task automatic answer_csts(output logic rdy);
    if (model_rdy != rdy_target) begin
      if (lag_left > 0)
        lag_left = lag_left - 1;
      else
        model_rdy = rdy_target;
    end
    rdy = model_rdy;
  endtask

  task automatic drop_and_restore();
    repeat (3) @(posedge user_clk);                // Link falls as the next header goes out
    link_up <= 1'b0;
    repeat (2) @(negedge user_clk);
    check_done(cfg_done, 1'b0, "cfg_done after link drop");
    check_idle(rq, "request stream after link drop");
    repeat (3) @(posedge user_clk);
    link_up <= 1'b1;
  endtask

  task automatic run_sequence(input logic drop_link);
    nvme_cfg_pkg::step_t s;
    int                  i;
    int                  delay;
    logic                rdy;
    logic                dropped;
    i          = 0;
    csts_reads = 0;
    dropped    = 1'b0;
    model_rdy  = 1'b1;                             // First wait loop must poll
    rdy_target = 1'b1;
    lag_left   = 0;
    while (i < 10) begin
      s        = nvme_cfg_pkg::step_t'(i);
      exp_step = s;
      @(req_done);
      if (is_posted(s)) begin
        if (s == nvme_cfg_pkg::cc_disable || s == nvme_cfg_pkg::cc_enable) begin
          rdy_target = (s == nvme_cfg_pkg::cc_enable);
          draw_bits(2, poll_lag);
          lag_left = poll_lag;
        end
        i = i + 1;
        if (drop_link && !dropped && s == nvme_cfg_pkg::aqa) begin
          drop_and_restore();
          dropped    = 1'b1;
          i          = 0;                          // Bring-up starts over
          model_rdy  = 1'b1;                       // Endpoint resets with the link
          rdy_target = 1'b1;
          lag_left   = 0;
        end
      end else begin
        draw_bits(3, delay);
        wait_quiet(delay + 1);
        if (s == nvme_cfg_pkg::bar_hi) begin
          send_cpl(1'b0, 1'b0);                    // Completed flag clear
          wait_quiet(5);
        end
        rdy = 1'b0;
        if (s == nvme_cfg_pkg::csts_wait_low || s == nvme_cfg_pkg::csts_wait_high)
          answer_csts(rdy);
        send_cpl(1'b1, rdy);
        if (s != nvme_cfg_pkg::csts_wait_low && s != nvme_cfg_pkg::csts_wait_high) begin
          i = i + 1;
        end else if (rdy == (s == nvme_cfg_pkg::csts_wait_high)) begin
          if (csts_reads != poll_lag + 1)
            stop_sim($sformatf("** Error at %0t ns: %0d CSTS reads, expected %0d",
                               $time, csts_reads, poll_lag + 1));
          csts_reads = 0;
          i          = i + 1;
        end
      end
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    rst_n        = 1'b0;
    link_up      = 1'b0;
    start_config = 1'b0;
    rc           = '0;
    exp_step     = nvme_cfg_pkg::cmd_reg;
    for (int run = 0; run < NUM_RUNS; run++) begin
      apply_reset();
      @(posedge user_clk);
      link_up <= 1'b1;
      repeat (10) begin
        @(negedge user_clk);
        check_idle(rq, "request stream before start");
        check_done(cfg_done, 1'b0, "cfg_done before start");
      end
      @(posedge user_clk);
      start_config <= 1'b1;
      run_sequence(run == 1);                      // Second run loses the link
      while (cfg_done !== 1'b1)
        @(negedge user_clk);
      repeat (20) begin
        @(negedge user_clk);
        check_done(cfg_done, 1'b1, "cfg_done after bring-up");
        check_idle(rq, "request stream after bring-up");
      end
      @(posedge user_clk);
      start_config <= 1'b0;
    end
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/nvme_configurator.sv
// Top level of the NVMe bring-up configurator
// Sequencer, request encoder and completion decoder
`default_nettype none

module nvme_configurator (
  input  wire logic                   user_clk,
  input  wire logic                   rst_n,
  input  wire logic                   link_up,
  input  wire logic                   start_config,   // Level
  input  wire nvme_cfg_pkg::rc_beat_t rc,
  output nvme_cfg_pkg::rq_beat_t      rq,
  output logic                        cfg_done
);

  nvme_cfg_pkg::req_cmd_t    req;        // Step strobe to encoder
  logic                      req_sent;   // Last beat of request out
  nvme_cfg_pkg::cpl_result_t cpl;

  // ----------------------------------------------------------
  // Blocks
  // ----------------------------------------------------------
  cfg_sequencer cfg_sequencer_i (
    .user_clk     (user_clk),
    .rst_n        (rst_n),
    .link_up      (link_up),
    .start_config (start_config),
    .req_sent     (req_sent),
    .cpl          (cpl),
    .req          (req),
    .cfg_done     (cfg_done)
  );

  rq_encoder rq_encoder_i (
    .user_clk (user_clk),
    .rst_n    (rst_n),
    .link_up  (link_up),
    .req      (req),
    .rq       (rq),
    .req_sent (req_sent)
  );

  rc_decoder rc_decoder_i (
    .user_clk (user_clk),
    .rst_n    (rst_n),
    .link_up  (link_up),
    .rc       (rc),
    .cpl      (cpl)
  );

endmodule

`default_nettype wire

// File: verilog/rc_decoder.sv
// Requester completion decoder
// Turns each closing completion beat into a one-cycle result
`default_nettype none

`include "nvme_cfg_defs.svh"

module rc_decoder (
  input  wire logic                   user_clk,
  input  wire logic                   rst_n,
  input  wire logic                   link_up,
  input  wire nvme_cfg_pkg::rc_beat_t rc,
  output nvme_cfg_pkg::cpl_result_t   cpl
);

  logic cpl_beat;    // Last beat of a completion
  logic valid_q;
  logic ok_q;
  logic rdy_q;

  assign cpl_beat = rc.tvalid && rc.tlast;

  always_ff @(posedge user_clk or negedge rst_n) begin
    if (!rst_n)
      valid_q <= 1'b0;
    else if (!link_up)
      valid_q <= 1'b0;
    else
      valid_q <= cpl_beat;
  end

  always_ff @(posedge user_clk) begin
    if (cpl_beat) begin
      ok_q  <= rc.tdata[`NVME_CPL_OK_BIT];   // Request completed
      rdy_q <= rc.tdata[`NVME_RDY_BIT];      // Only meaningful for CSTS
    end
  end

  always_comb begin
    cpl.valid = valid_q;
    cpl.ok    = ok_q;
    cpl.rdy   = rdy_q;
  end

  // One request in flight, so completions never come back to back
  a_cpl_pulse: assert property (
    @(posedge user_clk) disable iff (!rst_n)
    cpl.valid |=> !cpl.valid
  );

endmodule

`default_nettype wire

// File: verilog/rq_encoder.sv
// Requester request encoder
// Step table plus registered header and payload beat emitter
`default_nettype none

`include "nvme_cfg_defs.svh"

module rq_encoder (
  input  wire logic                   user_clk,
  input  wire logic                   rst_n,
  input  wire logic                   link_up,
  input  wire nvme_cfg_pkg::req_cmd_t req,
  output nvme_cfg_pkg::rq_beat_t      rq,
  output logic                        req_sent
);

  localparam nvme_cfg_pkg::addr_t bar0_base = {`NVME_BAR0_HI, `NVME_BAR0_LO};

  nvme_cfg_pkg::step_t     step_q;       // Step of the request in flight
  logic                    phase;        // Payload beat pending
  nvme_cfg_pkg::step_t     tbl_step;
  nvme_cfg_pkg::req_type_t tbl_type;
  logic [9:0]              tbl_reg;
  logic [7:0]              tbl_ofs;
  logic                    tbl_two_dw;
  nvme_cfg_pkg::dw_t       tbl_pay;
  logic [10:0]             dw_cnt;
  nvme_cfg_pkg::be_t       last_be;
  nvme_cfg_pkg::addr_t     hdr_addr;
  nvme_cfg_pkg::data_t     hdr_data;
  nvme_cfg_pkg::data_t     tdata_q;
  nvme_cfg_pkg::keep_t     tkeep_q;
  nvme_cfg_pkg::rq_user_t  tuser_q;
  logic                    tlast_q;
  logic                    tvalid_q;

  // ----------------------------------------------------------
  // Request table
  // ----------------------------------------------------------
  always_comb begin
    tbl_step   = phase ? step_q : req.step;
    tbl_type   = nvme_cfg_pkg::mem_wr;
    tbl_reg    = 10'd0;
    tbl_ofs    = 8'h00;
    tbl_two_dw = 1'b0;
    tbl_pay    = '0;
    case (tbl_step)
      nvme_cfg_pkg::cmd_reg: begin
        tbl_type = nvme_cfg_pkg::cfg_wr0;
        tbl_reg  = `NVME_CMD_REG;
        tbl_pay  = `NVME_CMD_VAL;
      end
      nvme_cfg_pkg::bar_lo: begin
        tbl_type = nvme_cfg_pkg::cfg_wr0;
        tbl_reg  = `NVME_BAR0_REG;
        tbl_pay  = `NVME_BAR0_LO;
      end
      nvme_cfg_pkg::bar_hi: begin
        tbl_type = nvme_cfg_pkg::cfg_wr0;
        tbl_reg  = `NVME_BAR1_REG;
        tbl_pay  = `NVME_BAR0_HI;
      end
      nvme_cfg_pkg::cc_disable: tbl_ofs = `NVME_CC_OFS;    // Writes CC.EN = 0
      nvme_cfg_pkg::csts_wait_low, nvme_cfg_pkg::csts_wait_high: begin
        tbl_type = nvme_cfg_pkg::mem_rd;
        tbl_ofs  = `NVME_CSTS_OFS;
      end
      nvme_cfg_pkg::aqa: begin
        tbl_ofs = `NVME_AQA_OFS;
        tbl_pay = `NVME_AQA_VAL;
      end
      nvme_cfg_pkg::asq: begin
        tbl_ofs    = `NVME_ASQ_OFS;
        tbl_two_dw = 1'b1;                     // 64-bit base, upper dword zero
        tbl_pay    = `NVME_ASQ_BASE;
      end
      nvme_cfg_pkg::acq: begin
        tbl_ofs    = `NVME_ACQ_OFS;
        tbl_two_dw = 1'b1;
        tbl_pay    = `NVME_ACQ_BASE;
      end
      nvme_cfg_pkg::cc_enable: begin
        tbl_ofs = `NVME_CC_OFS;
        tbl_pay = 32'h0000_0001;
      end
      default: ;
    endcase
  end

  // Header descriptor, tag fixed at zero
  always_comb begin
    dw_cnt  = tbl_two_dw ? 11'd2 : 11'd1;
    last_be = tbl_two_dw ? 4'b1111 : 4'b0000;
    if (tbl_type == nvme_cfg_pkg::cfg_wr0)
      hdr_addr = {52'd0, tbl_reg, 2'b00};
    else
      hdr_addr = bar0_base + nvme_cfg_pkg::addr_t'(tbl_ofs);
    hdr_data = {1'b0, 3'd0, 3'd0, 1'b1, `NVME_CPL_ID, 8'd0, `NVME_REQ_ID,
                1'b0, tbl_type, dw_cnt, hdr_addr};
  end

  // ----------------------------------------------------------
  // Beat registers
  // ----------------------------------------------------------
  always_ff @(posedge user_clk or negedge rst_n) begin
    if (!rst_n) begin
      tvalid_q <= 1'b0;
      tlast_q  <= 1'b0;
      req_sent <= 1'b0;
      phase    <= 1'b0;
    end else if (!link_up) begin
      tvalid_q <= 1'b0;
      tlast_q  <= 1'b0;
      req_sent <= 1'b0;
      phase    <= 1'b0;
    end else if (req.valid) begin
      tvalid_q <= 1'b1;                                  // Header beat
      tlast_q  <= (tbl_type == nvme_cfg_pkg::mem_rd);   // Read has no payload
      req_sent <= (tbl_type == nvme_cfg_pkg::mem_rd);
      phase    <= (tbl_type != nvme_cfg_pkg::mem_rd);
    end else if (phase) begin
      tvalid_q <= 1'b1;                                  // Payload beat
      tlast_q  <= 1'b1;
      req_sent <= 1'b1;
      phase    <= 1'b0;
    end else begin
      tvalid_q <= 1'b0;
      tlast_q  <= 1'b0;
      req_sent <= 1'b0;
    end
  end

  always_ff @(posedge user_clk) begin
    if (req.valid) begin
      step_q  <= req.step;
      tdata_q <= hdr_data;
      tkeep_q <= 4'b1111;
      tuser_q <= {{(`NVME_RQ_USER_W-8){1'b0}}, last_be, 4'b1111};
    end else if (phase) begin
      tdata_q <= nvme_cfg_pkg::data_t'(tbl_pay);
      tkeep_q <= tbl_two_dw ? 4'b0011 : 4'b0001;
      tuser_q <= '0;
    end
  end

  always_comb begin
    rq.tdata  = tdata_q;
    rq.tkeep  = tkeep_q;
    rq.tuser  = tuser_q;
    rq.tlast  = tlast_q;
    rq.tvalid = tvalid_q;
  end

  // Sequencer holds off the next request past the closing beat
  a_tlast_ends_request: assert property (
    @(posedge user_clk) disable iff (!rst_n)
    rq.tvalid && rq.tlast |=> !rq.tvalid
  );

endmodule

`default_nettype wire

// File: verilog/cfg_sequencer.sv
// Bring-up FSM of the NVMe configurator
// Issues one step at a time and waits for the send or the completion
`default_nettype none

module cfg_sequencer (
  input  wire logic                      user_clk,
  input  wire logic                      rst_n,
  input  wire logic                      link_up,
  input  wire logic                      start_config,
  input  wire logic                      req_sent,
  input  wire nvme_cfg_pkg::cpl_result_t cpl,
  output nvme_cfg_pkg::req_cmd_t         req,
  output logic                           cfg_done
);

  nvme_cfg_pkg::seq_state_t state;
  nvme_cfg_pkg::step_t      step;        // Step being issued or awaited
  nvme_cfg_pkg::step_t      next_step;
  logic                     csts_step;   // Status poll step
  logic                     need_cpl;    // Non-posted request
  logic                     rdy_want;    // RDY value that ends a poll

  // ----------------------------------------------------------
  // Step attributes
  // ----------------------------------------------------------
  always_comb begin
    next_step = nvme_cfg_pkg::step_t'(step + 4'd1);
    csts_step = (step == nvme_cfg_pkg::csts_wait_low) ||
                (step == nvme_cfg_pkg::csts_wait_high);
    need_cpl  = csts_step ||
                (step == nvme_cfg_pkg::cmd_reg) ||
                (step == nvme_cfg_pkg::bar_lo) ||
                (step == nvme_cfg_pkg::bar_hi);
    rdy_want  = (step == nvme_cfg_pkg::csts_wait_high);
  end

  // ----------------------------------------------------------
  // State machine
  // ----------------------------------------------------------
  always_ff @(posedge user_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= nvme_cfg_pkg::st_idle;
      step     <= nvme_cfg_pkg::cmd_reg;
      req      <= '0;
      cfg_done <= 1'b0;
    end else if (!link_up) begin
      state    <= nvme_cfg_pkg::st_idle;   // Link loss restarts bring-up
      step     <= nvme_cfg_pkg::cmd_reg;
      req      <= '0;
      cfg_done <= 1'b0;
    end else begin
      req.valid <= 1'b0;
      case (state)
        nvme_cfg_pkg::st_idle: begin
          if (start_config) begin
            step  <= nvme_cfg_pkg::cmd_reg;
            state <= nvme_cfg_pkg::st_issue;
          end
        end

        nvme_cfg_pkg::st_issue: begin
          req.valid <= 1'b1;
          req.step  <= step;
          state     <= nvme_cfg_pkg::st_sending;
        end

        nvme_cfg_pkg::st_sending: begin
          if (req_sent) begin
            if (need_cpl) begin
              state <= nvme_cfg_pkg::st_wait_cpl;
            end else begin
              step  <= next_step;              // Posted write
              state <= nvme_cfg_pkg::st_issue;
            end
          end
        end

        // A completion without the completed flag is dropped
        nvme_cfg_pkg::st_wait_cpl: begin
          if (cpl.valid && cpl.ok) begin
            if (!csts_step) begin
              step  <= next_step;
              state <= nvme_cfg_pkg::st_issue;
            end else if (cpl.rdy != rdy_want) begin
              state <= nvme_cfg_pkg::st_issue;   // Poll CSTS again
            end else if (step == nvme_cfg_pkg::csts_wait_high) begin
              state    <= nvme_cfg_pkg::st_done;
              cfg_done <= 1'b1;
            end else begin
              step  <= next_step;
              state <= nvme_cfg_pkg::st_issue;
            end
          end
        end

        nvme_cfg_pkg::st_done: begin
          cfg_done <= 1'b1;                    // Held until reset or link loss
        end

        default: begin
          state <= nvme_cfg_pkg::st_idle;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  a_req_from_issue: assert property (
    @(posedge user_clk) disable iff (!rst_n)
    $rose(req.valid) |-> $past(state) == nvme_cfg_pkg::st_issue
  );

  // Encoder must never report a send while nothing is outstanding
  a_no_sent_in_idle: assert property (
    @(posedge user_clk) disable iff (!rst_n)
    req_sent |-> state != nvme_cfg_pkg::st_idle
  );

endmodule

`default_nettype wire

// File: verilog/nvme_cfg_pkg.sv
// Shared types of the NVMe configurator
// Vector typedefs, request and state enums, stream and command structs
`default_nettype none

`include "nvme_cfg_defs.svh"

package nvme_cfg_pkg;

  typedef logic [`NVME_DATA_W-1:0]    data_t;
  typedef logic [`NVME_KEEP_W-1:0]    keep_t;
  typedef logic [`NVME_RQ_USER_W-1:0] rq_user_t;
  typedef logic [31:0]                dw_t;
  typedef logic [63:0]                addr_t;
  typedef logic [3:0]                 be_t;

  // Requester request type codes
  typedef enum logic [3:0] {
    mem_rd  = 4'b0000,
    mem_wr  = 4'b0001,
    cfg_wr0 = 4'b1010
  } req_type_t;

  // Bring-up steps in issue order
  typedef enum logic [3:0] {
    cmd_reg        = 4'd0,
    bar_lo         = 4'd1,
    bar_hi         = 4'd2,
    cc_disable     = 4'd3,
    csts_wait_low  = 4'd4,
    aqa            = 4'd5,
    asq            = 4'd6,
    acq            = 4'd7,
    cc_enable      = 4'd8,
    csts_wait_high = 4'd9
  } step_t;

  typedef enum logic [2:0] {
    st_idle,
    st_issue,
    st_sending,
    st_wait_cpl,
    st_done
  } seq_state_t;

  // ----------------------------------------------------------
  // Stream beats and internal commands
  // ----------------------------------------------------------
  typedef struct packed {
    data_t    tdata;
    keep_t    tkeep;
    rq_user_t tuser;
    logic     tlast;
    logic     tvalid;
  } rq_beat_t;

  typedef struct packed {
    data_t tdata;
    logic  tlast;
    logic  tvalid;
  } rc_beat_t;

  typedef struct packed {
    logic  valid;   // One-cycle strobe
    step_t step;
  } req_cmd_t;

  typedef struct packed {
    logic valid;    // One-cycle pulse
    logic ok;
    logic rdy;
  } cpl_result_t;

endpackage

`default_nettype wire

// File: verilog/nvme_cfg_defs.svh
// Stream widths, NVMe register map and bring-up constants
// Included by the package and by the request and completion blocks
`ifndef NVME_CFG_DEFS_SVH
`define NVME_CFG_DEFS_SVH

// ----------------------------------------------------------
// Stream widths
// ----------------------------------------------------------
`define NVME_DATA_W      128           // Requester and completer data
`define NVME_KEEP_W      4             // One bit per dword
`define NVME_RQ_USER_W   62

// Requester and completer IDs
`define NVME_REQ_ID      16'h0000      // Root port
`define NVME_CPL_ID      16'h0100      // Bus 1 device 0 function 0

// ----------------------------------------------------------
// BAR0 base and controller register offsets
// ----------------------------------------------------------
`define NVME_BAR0_LO     32'h0000_0000
`define NVME_BAR0_HI     32'h0000_0010

`define NVME_CC_OFS      8'h14         // Controller configuration
`define NVME_CSTS_OFS    8'h1C         // Controller status
`define NVME_AQA_OFS     8'h24         // Admin queue attributes
`define NVME_ASQ_OFS     8'h28         // Admin submission queue base
`define NVME_ACQ_OFS     8'h30         // Admin completion queue base

// Config space register numbers in dwords
`define NVME_CMD_REG     10'd1
`define NVME_BAR0_REG    10'd4
`define NVME_BAR1_REG    10'd5

// ----------------------------------------------------------
// Values written during bring-up
// ----------------------------------------------------------
`define NVME_CMD_VAL     32'h0000_0007 // Memory and IO space plus bus master
`define NVME_AQA_VAL     32'h000F_000F // 16 entries in each admin queue
`define NVME_ASQ_BASE    32'hFFFF_F100
`define NVME_ACQ_BASE    32'hFFFF_F200

// Completion beat fields
`define NVME_CPL_OK_BIT  30            // Request completed flag
`define NVME_RDY_BIT     96            // CSTS.RDY in first payload dword

`endif
